// File: design/video_pkg.sv
package video_pkg;

    // Palette index inside one layer, zero is transparent
    typedef logic [3:0] pxl_t;

    // Beam position
    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
    } pos_t;

    // Graphics ROM row request
    typedef struct packed {
        logic        cs;
        logic [13:0] addr;  // Code times 8 plus row
    } rom_req_t;

    // Final colour
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

endpackage

// File: design/bus_pkg.sv
package bus_pkg;

    // Wishbone classic, driven by the master
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [10:0] adr;
        logic [7:0]  dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;  // Zero when not acking
    } wb_rsp_t;

    // Address map
    localparam logic [10:0] TILE_BASE = 11'h000;  // 1024 bytes of tile codes
    localparam logic [10:0] SPR_BASE  = 11'h400;  // 8 sprites, 4 bytes each
    localparam logic [10:0] PAL_BASE  = 11'h500;  // 32 entries, 2 bytes each

endpackage

// File: design/video_timer.sv
module video_timer #(
    parameter int H_ACTIVE = 256,
    parameter int H_TOTAL  = 384,
    parameter int V_ACTIVE = 224,
    parameter int V_TOTAL  = 264
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            pxl_cen,
    output video_pkg::pos_t pos,
    output logic            lhbl,
    output logic            lvbl,
    output logic            hs,
    output logic            vs,
    output logic            hinit
);
    localparam logic [8:0] HS_START = 9'(H_ACTIVE + 16);
    localparam logic [8:0] HS_END   = 9'(H_ACTIVE + 48);
    localparam logic [8:0] VS_START = 9'(V_ACTIVE + 4);
    localparam logic [8:0] VS_END   = 9'(V_ACTIVE + 8);

    logic [8:0] hnext;
    logic [8:0] vnext;

    always_comb begin
        hnext = (pos.hdump == 9'(H_TOTAL - 1)) ? 9'd0 : pos.hdump + 9'd1;
        vnext = pos.vdump;
        if (hnext == 9'd0) begin  // Line wrap steps the vertical count
            vnext = (pos.vdump == 9'(V_TOTAL - 1)) ? 9'd0 : pos.vdump + 9'd1;
        end
    end

    // Flags are computed from the next position so they line up with pos
    always_ff @(posedge clk) begin
        if (rst) begin
            pos   <= '0;
            lhbl  <= 1'b1;
            lvbl  <= 1'b1;
            hs    <= 1'b0;
            vs    <= 1'b0;
            hinit <= 1'b0;
        end else if (pxl_cen) begin
            pos.hdump <= hnext;
            pos.vdump <= vnext;
            lhbl      <= hnext < 9'(H_ACTIVE);
            lvbl      <= vnext < 9'(V_ACTIVE);
            hs        <= hnext >= HS_START && hnext < HS_END;
            vs        <= vnext >= VS_START && vnext < VS_END;
            // Qualifies the enable that brings hdump to zero
            hinit     <= hnext == 9'(H_TOTAL - 1);
        end
    end

endmodule

// File: design/tile_layer.sv
module tile_layer (
    input  logic                clk,
    input  logic                rst,
    input  logic                pxl_cen,
    input  bus_pkg::wb_req_t    bus,
    output bus_pkg::wb_rsp_t    bus_rsp,
    input  video_pkg::pos_t     pos,
    input  logic                lhbl,
    output video_pkg::rom_req_t rom,
    input  logic [31:0]         rom_data,
    input  logic                rom_ok,
    output video_pkg::pxl_t     pxl
);
    logic [7:0]  code_ram [1024];
    logic        ack;
    logic [7:0]  wb_dat;
    logic        wb_wr;

    logic [7:0]  vline;       // Line the fetched tile belongs to
    logic [4:0]  fcol;        // Column of the fetched tile
    logic [7:0]  code_q;
    logic [2:0]  line_q;
    logic        fetch_pend;
    logic [31:0] row_q;       // Last row returned by the ROM
    logic [31:0] shift;

    assign wb_wr = bus.cyc && bus.stb && bus.we && !ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= bus.cyc && bus.stb && !ack;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_wr) begin
            code_ram[bus.adr[9:0]] <= bus.dat;
        end
        wb_dat <= code_ram[bus.adr[9:0]];
    end

    assign bus_rsp.ack = ack;
    assign bus_rsp.dat = ack ? wb_dat : 8'd0;

    // In blank every fetch targets the first tile of the next line
    always_comb begin
        if (lhbl) begin
            fcol  = pos.hdump[7:3] + 5'd1;
            vline = pos.vdump[7:0];
        end else begin
            fcol  = 5'd0;
            vline = pos.vdump[7:0] + 8'd1;
        end
    end

    // Code read at the first pixel of each tile, one tile ahead
    always_ff @(posedge clk) begin
        if (pxl_cen && pos.hdump[2:0] == 3'd0) begin
            code_q <= code_ram[{vline[7:3], fcol}];
            line_q <= vline[2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pend <= 1'b0;
            rom        <= '0;
            shift      <= '0;
        end else begin
            fetch_pend <= pxl_cen && pos.hdump[2:0] == 3'd0;
            if (fetch_pend && !rom.cs) begin
                rom.cs   <= 1'b1;
                rom.addr <= {3'd0, code_q, line_q};
            end else if (rom.cs && rom_ok) begin
                rom.cs <= 1'b0;
            end
            if (pxl_cen) begin
                // Load as hdump enters the next tile
                shift <= (pos.hdump[2:0] == 3'd7) ? row_q : shift >> 4;
            end
        end
    end

    // A late ok leaves the previous row in place
    always_ff @(posedge clk) begin
        if (rom.cs && rom_ok) begin
            row_q <= rom_data;
        end
    end

    assign pxl = lhbl ? shift[3:0] : 4'd0;

endmodule

// File: design/sprite_layer.sv
module sprite_layer #(
    parameter int H_ACTIVE = 256
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                pxl_cen,
    input  bus_pkg::wb_req_t    bus,
    output bus_pkg::wb_rsp_t    bus_rsp,
    input  video_pkg::pos_t     pos,
    input  logic                lhbl,
    input  logic                hinit,
    output video_pkg::rom_req_t rom,
    input  logic [31:0]         rom_data,
    input  logic                rom_ok,
    output video_pkg::pxl_t     pxl
);
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_SCAN  = 2'd1;
    localparam logic [1:0] ST_FETCH = 2'd2;
    localparam logic [1:0] ST_DRAW  = 2'd3;

    logic [7:0]  attr_ram [32];  // y, x, code, unused per entry
    logic [3:0]  lbuf [512];     // Two line halves
    logic        ack;
    logic [7:0]  wb_dat;

    logic [1:0]  st;
    logic [2:0]  idx;
    logic [2:0]  cnt;
    logic        half;           // Half being displayed
    logic        lhbl_l;
    logic [7:0]  spr_y, spr_x, spr_code;
    logic [7:0]  dy;
    logic        hit;
    logic [7:0]  xs;
    logic [31:0] row;
    logic [8:0]  draw_x;
    logic        draw_we;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= bus.cyc && bus.stb && !ack;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.cyc && bus.stb && bus.we && !ack) begin
            attr_ram[bus.adr[4:0]] <= bus.dat;
        end
        wb_dat <= attr_ram[bus.adr[4:0]];
    end

    assign bus_rsp.ack = ack;
    assign bus_rsp.dat = ack ? wb_dat : 8'd0;

    always_comb begin
        spr_y    = attr_ram[{idx, 2'd0}];
        spr_x    = attr_ram[{idx, 2'd1}];
        spr_code = attr_ram[{idx, 2'd2}];
        dy       = pos.vdump[7:0] + 8'd1 - spr_y;  // Row inside the sprite on the next line
        hit      = dy[7:3] == 5'd0;
        draw_x   = {1'b0, xs} + {6'd0, cnt};
        draw_we  = st == ST_DRAW && row[3:0] != 4'd0 && draw_x < 9'(H_ACTIVE);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st     <= ST_IDLE;
            idx    <= 3'd0;
            cnt    <= 3'd0;
            half   <= 1'b0;
            lhbl_l <= 1'b1;
            rom    <= '0;
        end else begin
            lhbl_l <= lhbl;
            if (pxl_cen && hinit) begin
                half   <= ~half;   // Drawn half goes on screen
                st     <= ST_IDLE; // Unfinished scans are dropped
                rom.cs <= 1'b0;
            end else begin
                case (st)
                    ST_IDLE: if (lhbl_l && !lhbl) begin
                        idx <= 3'd0;
                        st  <= ST_SCAN;
                    end
                    ST_SCAN: if (hit) begin
                        rom.cs   <= 1'b1;
                        rom.addr <= {3'd0, spr_code, dy[2:0]};
                        xs       <= spr_x;
                        st       <= ST_FETCH;
                    end else if (idx == 3'd7) begin
                        st <= ST_IDLE;
                    end else begin
                        idx <= idx + 3'd1;
                    end
                    ST_FETCH: if (rom_ok) begin
                        rom.cs <= 1'b0;
                        row    <= rom_data;
                        cnt    <= 3'd0;
                        st     <= ST_DRAW;
                    end
                    default: begin  // One pixel per clock
                        row <= row >> 4;
                        cnt <= cnt + 3'd1;
                        if (cnt == 3'd7) begin
                            idx <= idx + 3'd1;
                            st  <= (idx == 3'd7) ? ST_IDLE : ST_SCAN;
                        end
                    end
                endcase
            end
        end
    end

    // Clear behind the beam, draw into the other half
    always_ff @(posedge clk) begin
        if (pxl_cen && lhbl) begin
            lbuf[{half, pos.hdump[7:0]}] <= 4'd0;
        end else if (draw_we) begin
            lbuf[{~half, draw_x[7:0]}] <= row[3:0];
        end
    end

    assign pxl = lhbl ? lbuf[{half, pos.hdump[7:0]}] : 4'd0;

endmodule

// File: design/color_mixer.sv
module color_mixer (
    input  logic             clk,
    input  logic             rst,
    input  logic             pxl_cen,
    input  bus_pkg::wb_req_t bus,
    output bus_pkg::wb_rsp_t bus_rsp,
    input  video_pkg::pxl_t  tile_pxl,
    input  video_pkg::pxl_t  spr_pxl,
    input  logic             lhbl,
    input  logic             lvbl,
    output video_pkg::rgb_t  rgb,
    output logic             lhbl_dly,
    output logic             lvbl_dly
);
    logic [7:0] pal_ram [64];
    logic       ack;
    logic [7:0] wb_dat;
    logic [4:0] pal_idx;   // Upper half serves sprites
    logic       lhbl1, lvbl1;
    logic [7:0] pal_lo;    // Green and red
    logic [7:0] pal_hi;    // Blue in the low nibble

    always_ff @(posedge clk) begin
        if (rst) begin
            ack     <= 1'b0;
            pal_ram <= '{default: 8'd0};
        end else begin
            ack <= bus.cyc && bus.stb && !ack;
            if (bus.cyc && bus.stb && bus.we && !ack) begin
                pal_ram[bus.adr[5:0]] <= bus.dat;
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_dat <= pal_ram[bus.adr[5:0]];
    end

    assign bus_rsp.ack = ack;
    assign bus_rsp.dat = ack ? wb_dat : 8'd0;

    assign pal_lo = pal_ram[{pal_idx, 1'b0}];
    assign pal_hi = pal_ram[{pal_idx, 1'b1}];

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (spr_pxl != 4'd0) begin
                pal_idx <= {1'b1, spr_pxl};
            end else begin
                pal_idx <= {1'b0, tile_pxl};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lhbl1    <= 1'b0;
            lvbl1    <= 1'b0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            rgb      <= '0;
        end else if (pxl_cen) begin
            lhbl1    <= lhbl;
            lvbl1    <= lvbl;
            lhbl_dly <= lhbl1;
            lvbl_dly <= lvbl1;
            if (lhbl1 && lvbl1) begin
                rgb <= '{red: pal_lo[3:0], green: pal_lo[7:4], blue: pal_hi[3:0]};
            end else begin
                rgb <= '0;  // Black in blanking
            end
        end
    end

endmodule

// File: design/video_top.sv
module video_top #(
    parameter int H_ACTIVE = 256,
    parameter int H_TOTAL  = 384,
    parameter int V_ACTIVE = 224,
    parameter int V_TOTAL  = 264
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                pxl_cen,
    input  bus_pkg::wb_req_t    bus,
    output bus_pkg::wb_rsp_t    bus_rsp,
    output video_pkg::rom_req_t tile_rom,
    input  logic [31:0]         tile_rom_data,
    input  logic                tile_rom_ok,
    output video_pkg::rom_req_t spr_rom,
    input  logic [31:0]         spr_rom_data,
    input  logic                spr_rom_ok,
    output video_pkg::rgb_t     rgb,
    output logic                hs,
    output logic                vs,
    output logic                lhbl_dly,
    output logic                lvbl_dly
);
    video_pkg::pos_t  pos;
    logic             lhbl, lvbl, hinit;
    video_pkg::pxl_t  tile_pxl, spr_pxl;
    bus_pkg::wb_req_t tile_req, spr_req, pal_req;
    bus_pkg::wb_rsp_t tile_rsp, spr_rsp, pal_rsp;

    // Strobe only reaches the selected block
    always_comb begin
        tile_req     = bus;
        spr_req      = bus;
        pal_req      = bus;
        tile_req.stb = bus.stb && bus.adr[10] == bus_pkg::TILE_BASE[10];
        spr_req.stb  = bus.stb && bus.adr[10:5] == bus_pkg::SPR_BASE[10:5];
        pal_req.stb  = bus.stb && bus.adr[10:6] == bus_pkg::PAL_BASE[10:6];
        bus_rsp.ack  = tile_rsp.ack | spr_rsp.ack | pal_rsp.ack;
        bus_rsp.dat  = tile_rsp.dat | spr_rsp.dat | pal_rsp.dat;
    end

    video_timer #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
    ) u_timer (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .pos(pos),
        .lhbl(lhbl), .lvbl(lvbl), .hs(hs), .vs(vs), .hinit(hinit)
    );

    tile_layer u_tile (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .bus(tile_req), .bus_rsp(tile_rsp),
        .pos(pos), .lhbl(lhbl), .rom(tile_rom), .rom_data(tile_rom_data),
        .rom_ok(tile_rom_ok), .pxl(tile_pxl)
    );

    sprite_layer #(.H_ACTIVE(H_ACTIVE)) u_sprite (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .bus(spr_req), .bus_rsp(spr_rsp),
        .pos(pos), .lhbl(lhbl), .hinit(hinit), .rom(spr_rom), .rom_data(spr_rom_data),
        .rom_ok(spr_rom_ok), .pxl(spr_pxl)
    );

    color_mixer u_mixer (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .bus(pal_req), .bus_rsp(pal_rsp),
        .tile_pxl(tile_pxl), .spr_pxl(spr_pxl), .lhbl(lhbl), .lvbl(lvbl),
        .rgb(rgb), .lhbl_dly(lhbl_dly), .lvbl_dly(lvbl_dly)
    );

endmodule

// File: test/video_props.sv
module video_props #(
    parameter int H_TOTAL = 384,
    parameter int V_TOTAL = 264
) (
    input logic                clk,
    input logic                rst,
    input logic                pxl_cen,
    input bus_pkg::wb_req_t    bus,
    input bus_pkg::wb_rsp_t    bus_rsp,
    input video_pkg::rom_req_t tile_rom,
    input logic                tile_rom_ok,
    input video_pkg::rom_req_t spr_rom,
    input logic                spr_rom_ok,
    input video_pkg::rgb_t     rgb,
    input logic                hs,
    input logic                vs,
    input logic                lhbl_dly,
    input logic                lvbl_dly
);
    int   err_cnt = 0;  // Read by the testbench
    logic hs_q;
    logic vs_q;
    logic hs_seen;
    logic vs_seen;
    logic wr_seen;
    int   hs_cnt;       // Pixel enables since the last hs rise
    int   vs_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            hs_q    <= 1'b0;
            vs_q    <= 1'b0;
            hs_seen <= 1'b0;
            vs_seen <= 1'b0;
            wr_seen <= 1'b0;
            hs_cnt  <= 0;
            vs_cnt  <= 0;
        end else begin
            hs_q <= hs;
            vs_q <= vs;
            if (hs && !hs_q) begin
                hs_cnt  <= pxl_cen ? 1 : 0;
                hs_seen <= 1'b1;
            end else if (pxl_cen) begin
                hs_cnt <= hs_cnt + 1;
            end
            if (vs && !vs_q) begin
                vs_cnt  <= pxl_cen ? 1 : 0;
                vs_seen <= 1'b1;
            end else if (pxl_cen) begin
                vs_cnt <= vs_cnt + 1;
            end
            if (bus.cyc && bus.stb && bus.we) begin
                wr_seen <= 1'b1;
            end
        end
    end

    // Outputs idle right after reset
    a_reset: assert property (@(posedge clk) $past(rst) |-> !hs && !vs && !bus_rsp.ack
            && !tile_rom.cs && !spr_rom.cs && rgb == '0)
        else begin
            err_cnt++;
            $error("outputs not idle after reset");
        end

    a_dark: assert property (@(posedge clk) !wr_seen |-> rgb == '0)
        else begin
            err_cnt++;
            $error("rgb nonzero before the first bus write");
        end

    a_ack_delay: assert property (@(posedge clk) disable iff (rst)
            bus.cyc && bus.stb && !bus_rsp.ack |=> bus_rsp.ack)
        else begin
            err_cnt++;
            $error("ack did not follow stb by one cycle");
        end

    a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
            bus_rsp.ack |-> $past(bus.cyc && bus.stb) ##1 !bus_rsp.ack)
        else begin
            err_cnt++;
            $error("ack without a request or longer than one cycle");
        end

    a_hs_period: assert property (@(posedge clk) disable iff (rst)
            hs && !hs_q && hs_seen |-> hs_cnt == H_TOTAL)
        else begin
            err_cnt++;
            $error("hs period is %0d pixel enables", hs_cnt);
        end

    a_vs_period: assert property (@(posedge clk) disable iff (rst)
            vs && !vs_q && vs_seen |-> vs_cnt == H_TOTAL * V_TOTAL)
        else begin
            err_cnt++;
            $error("vs period is %0d pixel enables", vs_cnt);
        end

    // Black outside the visible area
    a_blank: assert property (@(posedge clk) disable iff (rst)
            !(lhbl_dly && lvbl_dly) |-> rgb == '0)
        else begin
            err_cnt++;
            $error("rgb nonzero during blanking");
        end

    a_tile_addr: assert property (@(posedge clk) disable iff (rst)
            tile_rom.cs && !tile_rom_ok |=> tile_rom.cs && $stable(tile_rom.addr))
        else begin
            err_cnt++;
            $error("tile ROM request changed before ok");
        end

    // Sprite requests may be dropped at hinit, the address still holds
    a_spr_addr: assert property (@(posedge clk) disable iff (rst)
            spr_rom.cs && !spr_rom_ok |=> $stable(spr_rom.addr))
        else begin
            err_cnt++;
            $error("sprite ROM address changed before ok");
        end

endmodule

bind video_top video_props #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)) u_props (
    .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .bus(bus), .bus_rsp(bus_rsp),
    .tile_rom(tile_rom), .tile_rom_ok(tile_rom_ok), .spr_rom(spr_rom),
    .spr_rom_ok(spr_rom_ok), .rgb(rgb), .hs(hs), .vs(vs),
    .lhbl_dly(lhbl_dly), .lvbl_dly(lvbl_dly)
);

// File: test/video_tb.sv
module video_tb;
    localparam int H_ACTIVE      = 64;
    localparam int H_TOTAL       = 96;
    localparam int V_ACTIVE      = 32;
    localparam int V_TOTAL       = 40;
    localparam int FRAME_CYCLES  = 2 * H_TOTAL * V_TOTAL;  // pxl_cen on every other clock
    localparam int TIMEOUT       = 3 * FRAME_CYCLES + 2000;
    localparam int SPR_X         = 16;
    localparam int SPR_Y         = 8;
    localparam int SPR_CODE      = 45;
    localparam int SPRITE_PIXELS = 64;
    localparam video_pkg::rgb_t RED  = '{red: 4'hF, green: 4'h0, blue: 4'h0};
    localparam video_pkg::rgb_t BLUE = '{red: 4'h0, green: 4'h0, blue: 4'hF};

    logic                clk;
    logic                rst;
    logic                pxl_cen;
    bus_pkg::wb_req_t    bus;
    bus_pkg::wb_rsp_t    bus_rsp;
    video_pkg::rom_req_t tile_rom;
    logic [31:0]         tile_rom_data;
    logic                tile_rom_ok;
    video_pkg::rom_req_t spr_rom;
    logic [31:0]         spr_rom_data;
    logic                spr_rom_ok;
    video_pkg::rgb_t     rgb;
    logic                hs;
    logic                vs;
    logic                lhbl_dly;
    logic                lvbl_dly;

    int tile_delay [64];  // ok delays, drawn once from the seeded generator
    int spr_delay [64];
    int tile_ptr;
    int spr_ptr;
    int tile_wait;
    int spr_wait;
    int cycles;
    int spr_rows;         // Sprite rows returned since the address check began
    logic addr_check;

    video_top #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
    ) u_video_top (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .bus(bus), .bus_rsp(bus_rsp),
        .tile_rom(tile_rom), .tile_rom_data(tile_rom_data), .tile_rom_ok(tile_rom_ok),
        .spr_rom(spr_rom), .spr_rom_data(spr_rom_data), .spr_rom_ok(spr_rom_ok),
        .rgb(rgb), .hs(hs), .vs(vs), .lhbl_dly(lhbl_dly), .lvbl_dly(lvbl_dly)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        #1;
        pxl_cen = ~pxl_cen;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    // One classic cycle with an idle clock before it
    task automatic bus_cycle(input logic we, input logic [10:0] adr, input logic [7:0] wdat,
                             output logic [7:0] rdat);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        bus = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!bus_rsp.ack && waited < 8);
        if (!bus_rsp.ack) begin
            stop_with_failure("no ack from the bus slave");
        end
        check_value("ack_latency", 32'(waited), 32'd1);
        rdat = bus_rsp.dat;
        bus  = '0;
    endtask

    task automatic write_byte(input logic [10:0] adr, input logic [7:0] dat);
        logic [7:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic read_byte(input logic [10:0] adr, output logic [7:0] dat);
        bus_cycle(1'b0, adr, 8'd0, dat);
    endtask

    task automatic check_readback(input logic [10:0] adr, input string name);
        logic [7:0] wdat;
        logic [7:0] rdat;
        wdat = 8'($urandom);
        write_byte(adr, wdat);
        read_byte(adr, rdat);
        check_value(name, 32'(rdat), 32'(wdat));
    endtask

    // Classify each visible pixel over one frame, vs rise to vs rise
    task automatic count_frame(output int red_n, output int blue_n, output int other_n);
        int n;
        red_n   = 0;
        blue_n  = 0;
        other_n = 0;
        n       = 0;
        @(negedge clk);
        while (vs) @(negedge clk);
        while (!vs) @(negedge clk);
        while (n < H_TOTAL * V_TOTAL) begin
            @(negedge clk);
            if (pxl_cen) begin
                n++;
                if (lhbl_dly && lvbl_dly) begin
                    if (rgb == RED) red_n++;
                    else if (rgb == BLUE) blue_n++;
                    else other_n++;
                end
            end
        end
    endtask

    // Tile ROM rows are all 1, sprite rows all 2
    always @(posedge clk) begin
        #1;
        if (tile_rom_ok) begin
            tile_rom_ok = 1'b0;
        end else if (tile_rom.cs) begin
            if (tile_wait == 0) begin
                tile_rom_ok = 1'b1;
                tile_wait   = tile_delay[tile_ptr];
                tile_ptr    = (tile_ptr + 1) % 64;
            end else begin
                tile_wait = tile_wait - 1;
            end
        end
    end

    always @(posedge clk) begin
        #1;
        if (spr_rom_ok) begin
            spr_rom_ok = 1'b0;
        end else if (spr_rom.cs) begin
            if (spr_wait == 0) begin
                if (addr_check) begin  // Code times 8 plus the row inside the sprite
                    check_value("spr_rom_addr", 32'(spr_rom.addr),
                                32'(SPR_CODE * 8 + spr_rows % 8));
                    spr_rows = spr_rows + 1;
                end
                spr_rom_ok = 1'b1;
                spr_wait   = spr_delay[spr_ptr];
                spr_ptr    = (spr_ptr + 1) % 64;
            end else begin
                spr_wait = spr_wait - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT) begin
            stop_with_failure("timeout: the run did not finish in the expected number of cycles");
        end
    end

    always @(negedge clk) begin
        if (u_video_top.u_props.err_cnt != 0) begin
            stop_with_failure("a bound assertion failed");
        end
    end

    initial begin
        int red_n;
        int blue_n;
        int other_n;
        void'($urandom(37));
        clk           = 1'b0;
        rst           = 1'b1;
        pxl_cen       = 1'b0;
        bus           = '0;
        tile_rom_data = 32'h1111_1111;
        tile_rom_ok   = 1'b0;
        spr_rom_data  = 32'h2222_2222;
        spr_rom_ok    = 1'b0;
        cycles        = 0;
        spr_rows      = 0;
        addr_check    = 1'b0;
        for (int i = 0; i < 64; i++) begin
            tile_delay[i] = $urandom_range(3, 0);
            spr_delay[i]  = $urandom_range(3, 0);
        end
        tile_wait = tile_delay[0];
        spr_wait  = spr_delay[0];
        tile_ptr  = 1;
        spr_ptr   = 1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        check_readback(bus_pkg::TILE_BASE + 11'h155, "tile_ram");
        check_readback(bus_pkg::SPR_BASE + 11'h03, "sprite_ram");
        check_readback(bus_pkg::PAL_BASE + 11'h2A, "palette_ram");

        for (int a = 0; a < 1024; a++) begin
            write_byte(bus_pkg::TILE_BASE + 11'(a), 8'h00);
        end
        // Sprite 0 on screen, the rest parked below the frame
        for (int k = 0; k < 8; k++) begin
            write_byte(bus_pkg::SPR_BASE + 11'(4 * k), (k == 0) ? 8'(SPR_Y) : 8'd200);
            write_byte(bus_pkg::SPR_BASE + 11'(4 * k + 1), (k == 0) ? 8'(SPR_X) : 8'd0);
            write_byte(bus_pkg::SPR_BASE + 11'(4 * k + 2), (k == 0) ? 8'(SPR_CODE) : 8'd0);
            write_byte(bus_pkg::SPR_BASE + 11'(4 * k + 3), 8'd0);
        end
        write_byte(bus_pkg::PAL_BASE + 11'd2, 8'h0F);   // Entry 1 red
        write_byte(bus_pkg::PAL_BASE + 11'd3, 8'h00);
        write_byte(bus_pkg::PAL_BASE + 11'd36, 8'h00);  // Entry 18 blue
        write_byte(bus_pkg::PAL_BASE + 11'd37, 8'h0F);

        // From this frame on sprite 0 is the only hit, fetched top row first
        @(posedge vs);
        addr_check = 1'b1;

        count_frame(red_n, blue_n, other_n);
        check_value("blue_pixels", 32'(blue_n), 32'(SPRITE_PIXELS));
        check_value("red_pixels", 32'(red_n), 32'(H_ACTIVE * V_ACTIVE - SPRITE_PIXELS));
        check_value("other_pixels", 32'(other_n), 32'd0);

        if (u_video_top.u_props.err_cnt == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            stop_with_failure("a bound assertion failed");
        end
    end

endmodule

// File: compile.f
design/video_pkg.sv
design/bus_pkg.sv
design/video_timer.sv
design/tile_layer.sv
design/sprite_layer.sv
design/color_mixer.sv
design/video_top.sv
test/video_props.sv
test/video_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = video_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+100
PASS_MSG  = >>> PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
